/* include/ifu_err_defs.svh */
// widths and counts shared by the ifu error datapath
// each tag word carries one parity bit above IFU_TAG_W
// error addresses are 16-byte granular, so bits below IFU_EADR_LO are never stored
`ifndef IFU_ERR_DEFS_SVH
`define IFU_ERR_DEFS_SVH

// ------------------------------
// array shape
// ------------------------------
// icache ways, one tag word per way
`define IFU_WAYS     4
// hardware threads, one error address register each
`define IFU_THREADS  4

// ------------------------------
// field widths
// ------------------------------
// tag bits per way, parity excluded
`define IFU_TAG_W    28
// fetched instruction incl. parity bit
`define IFU_INST_W   34
`define IFU_IMASK_W  39
// error address bounds
`define IFU_EADR_HI  47
`define IFU_EADR_LO  4
`define IFU_EADR_W   (`IFU_EADR_HI - `IFU_EADR_LO + 1)
// asi load result toward the lsu
`define IFU_LDXA_W   64

`endif

/* design/ifu_err_pkg.sv */
// types shared by the error datapath stages
// select codes arrive encoded; error-address codes above ASI_WR behave as HOLD
// the asi result word is one 64-bit value read through two field views
`include "ifu_err_defs.svh"

package ifu_err_pkg;

   // load source of a per-thread error address register
   typedef enum logic [2:0] {
      HOLD   = 3'd0,
      IRF    = 3'd1,
      LSU    = 3'd2,
      PC     = 3'd3,
      ASI_WR = 3'd4
   } eadr_src_e;

   // asi load result source
   typedef enum logic [1:0] {
      TAG   = 2'd0,
      EADR  = 2'd1,
      IMASK = 2'd2,
      INST  = 2'd3
   } asi_src_e;

   // thread index, also used to pick a way
   typedef logic [$clog2(`IFU_THREADS)-1:0] thread_t;

   // ------------------------------
   // asi result views
   // ------------------------------
   // icache tag diagnostic read
   typedef struct packed {
      logic [28:0]           zero_hi;
      logic                  valid;
      logic                  zero_33;
      logic                  parity;
      logic [3:0]            zero_lo;
      logic [`IFU_TAG_W-1:0] tag;
   } ldxa_tag_view_t;

   // error address read, bits 3:0 read as zero
   typedef struct packed {
      logic [`IFU_LDXA_W-`IFU_EADR_HI-2:0] zero_hi;
      logic [`IFU_EADR_W-1:0]              addr;
      logic [`IFU_EADR_LO-1:0]             zero_lo;
   } ldxa_addr_view_t;

   typedef union packed {
      ldxa_tag_view_t  tag_view;
      ldxa_addr_view_t addr_view;
   } ldxa_word_u;

endpackage

/* design/ifu_err_parity.sv */
// decode stage of the error datapath
// tags and valid bits are flopped; tag parity is checked on the flopped copy
// instruction parity is checked in the same cycle, no flop
// a flag of 1 means odd parity over the whole word incl. its parity bit
`timescale 1ns/100ps
`include "ifu_err_defs.svh"

module ifu_err_parity (
   input  logic                                rclk,
   input  logic                                reset,
   input  logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]  ict_tags_f,
   input  logic [`IFU_WAYS-1:0]                icv_valid_f,
   input  logic [`IFU_INST_W-1:0]              fet_data_s1,
   input  logic [`IFU_INST_W-1:0]              nir_data_s1,
   output logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]  tags_s1,
   output logic [`IFU_WAYS-1:0]                valid_s1,
   output logic [`IFU_WAYS-1:0]                tag_pe_s1,
   output logic                                fet_pe_s1,
   output logic                                nir_pe_s1
);

   import ifu_err_pkg::*;

   // highest way index, bounds the per-way checkers
   localparam thread_t last_way = thread_t'(`IFU_WAYS - 1);

   // ------------------------------
   // tag and valid capture
   // ------------------------------
   // tag array read, all ways at once
   always_ff @(posedge rclk) begin
      tags_s1 <= ict_tags_f;
   end

   // valid bits are control state
   always_ff @(posedge rclk) begin
      if (reset) begin
         valid_s1 <= '0;
      end else begin
         valid_s1 <= icv_valid_f;
      end
   end

   // ------------------------------
   // tag parity
   // ------------------------------
   // one xor tree per way
   // parity bit sits in the top bit of each way
   for (genvar w = 0; w <= last_way; w++) begin : g_way
      assign tag_pe_s1[w] = ^tags_s1[w];
   end

   // ------------------------------
   // instruction parity
   // ------------------------------
   // fetched instruction
   assign fet_pe_s1 = ^fet_data_s1;

   // next instruction register, same check
   assign nir_pe_s1 = ^nir_data_s1;

endmodule

/* design/ifu_err_addr_bank.sv */
// execute stage of the error datapath
// pc source is the fetch pc two edges back, irf and lsu sources one edge back
// asi store data is taken directly at the edge where ASI_WR is sampled
// select codes are not staged; a register loads at the edge its code is sampled
// reset clears all error address registers
`timescale 1ns/100ps
`include "ifu_err_defs.svh"

module ifu_err_addr_bank (
   input  logic                                              rclk,
   input  logic                                              reset,
   input  logic [47:0]                                       pc_f,
   input  logic [7:0]                                        exu_err_reg_m,
   input  logic [7:0]                                        exu_err_synd_m,
   input  logic [`IFU_EADR_HI:`IFU_EADR_LO]                  lsu_err_addr,
   input  ifu_err_pkg::eadr_src_e [`IFU_THREADS-1:0]         eadr_sel,
   input  logic [47:0]                                       asi_wr_data,
   output logic [`IFU_THREADS-1:0][`IFU_EADR_HI:`IFU_EADR_LO] err_addr
);

   import ifu_err_pkg::*;

   // staged source values
   logic [`IFU_EADR_HI:`IFU_EADR_LO] pc_s1;
   logic [`IFU_EADR_HI:`IFU_EADR_LO] pc_d1;
   logic [7:0]                       irf_reg_w;
   logic [7:0]                       irf_synd_w;
   logic [7:0]                       irf_reg_fix_w;
   logic [`IFU_EADR_HI:`IFU_EADR_LO] lsu_addr_w;
   logic [`IFU_EADR_HI:`IFU_EADR_LO] irf_src;

   // ------------------------------
   // source staging
   // ------------------------------
   // pc of the latest access, then one more cycle
   // low nibble is below error address granularity
   always_ff @(posedge rclk) begin
      pc_s1 <= pc_f[`IFU_EADR_HI:`IFU_EADR_LO];
      pc_d1 <= pc_s1;
   end

   // irf register number and syndrome, m to w
   always_ff @(posedge rclk) begin
      irf_reg_w  <= exu_err_reg_m;
      irf_synd_w <= exu_err_synd_m;
   end

   // lsu error address, one stage
   always_ff @(posedge rclk) begin
      lsu_addr_w <= lsu_err_addr;
   end

   // ------------------------------
   // irf register number fix
   // ------------------------------
   // bit 4 is flipped when bits 5 and 3 are both set
   assign irf_reg_fix_w = {irf_reg_w[7:5],
                           irf_reg_w[4] ^ (irf_reg_w[5] & irf_reg_w[3]),
                           irf_reg_w[3:0]};

   // syndrome above the register number, 4-bit gap between them
   assign irf_src = {24'b0, irf_synd_w, 4'b0, irf_reg_fix_w};

   // ------------------------------
   // per-thread error address
   // ------------------------------
   for (genvar t = 0; t < `IFU_THREADS; t++) begin : g_thr
      logic [`IFU_EADR_HI:`IFU_EADR_LO] eadr_nxt;
      logic [`IFU_EADR_HI:`IFU_EADR_LO] eadr_q;

      // source select, unused codes keep the old value
      always_comb begin
         case (eadr_sel[t])
            IRF:     eadr_nxt = irf_src;
            LSU:     eadr_nxt = lsu_addr_w;
            PC:      eadr_nxt = pc_d1;
            ASI_WR:  eadr_nxt = asi_wr_data[`IFU_EADR_HI:`IFU_EADR_LO];
            default: eadr_nxt = eadr_q;
         endcase
      end

      always_ff @(posedge rclk) begin
         if (reset) begin
            eadr_q <= '0;
         end else begin
            eadr_q <= eadr_nxt;
         end
      end

      assign err_addr[t] = eadr_q;
   end

endmodule

/* design/ifu_err_asi_read.sv */
// result stage of the error datapath
// the asi result is flopped once; it shows the source selected one cycle earlier
// way and thread selects are binary indices, not one-hot
// reset clears the instruction mask and the result flop
`timescale 1ns/100ps
`include "ifu_err_defs.svh"

module ifu_err_asi_read (
   input  logic                                              rclk,
   input  logic                                              reset,
   input  logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]                tags_s1,
   input  logic [`IFU_WAYS-1:0]                              valid_s1,
   input  logic [`IFU_THREADS-1:0][`IFU_EADR_HI:`IFU_EADR_LO] err_addr,
   input  ifu_err_pkg::asi_src_e                             asi_src,
   input  ifu_err_pkg::thread_t                              asi_way,
   input  ifu_err_pkg::thread_t                              asi_thr,
   input  logic [`IFU_INST_W-1:0]                            inst_asi_data_s,
   input  logic                                              ld_imask,
   input  logic [47:0]                                       asi_wr_data,
   output logic [`IFU_LDXA_W-1:0]                            ldxa_data_w2,
   output logic [`IFU_IMASK_W-1:0]                           imask
);

   import ifu_err_pkg::*;

   // selected result before the output flop
   ldxa_word_u ldxa_word_s;

   // ------------------------------
   // instruction mask
   // ------------------------------
   // loaded by asi store, holds otherwise
   always_ff @(posedge rclk) begin
      if (reset) begin
         imask <= '0;
      end else if (ld_imask) begin
         imask <= asi_wr_data[`IFU_IMASK_W-1:0];
      end
   end

   // ------------------------------
   // result select and format
   // ------------------------------
   always_comb begin
      ldxa_word_s = '0;
      case (asi_src)
         // tag diagnostic read of one way
         TAG: begin
            ldxa_word_s.tag_view.valid  = valid_s1[asi_way];
            ldxa_word_s.tag_view.parity = tags_s1[asi_way][`IFU_TAG_W];
            ldxa_word_s.tag_view.tag    = tags_s1[asi_way][`IFU_TAG_W-1:0];
         end
         // error address of one thread
         EADR: begin
            ldxa_word_s.addr_view.addr = err_addr[asi_thr];
         end
         // mask right aligned
         IMASK: begin
            ldxa_word_s = {{(`IFU_LDXA_W - `IFU_IMASK_W){1'b0}}, imask};
         end
         // parity bit moves above the 33 data bits
         INST: begin
            ldxa_word_s = {{(`IFU_LDXA_W - `IFU_INST_W){1'b0}},
                           inst_asi_data_s[0],
                           inst_asi_data_s[`IFU_INST_W-1:1]};
         end
      endcase
   end

   // ------------------------------
   // output flop toward the lsu
   // ------------------------------
   always_ff @(posedge rclk) begin
      if (reset) begin
         ldxa_data_w2 <= '0;
      end else begin
         ldxa_data_w2 <= ldxa_word_s;
      end
   end

endmodule

/* design/ifu_err_dp.sv */
// ifu error datapath, top level
// decode stage parity, execute stage error addresses, result stage asi read
// plain strobes and levels, no handshake, a new asi read may start every cycle
`timescale 1ns/100ps
`include "ifu_err_defs.svh"

module ifu_err_dp (
   input  logic                                      rclk,
   input  logic                                      reset,
   // decode stage
   input  logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]        ict_tags_f,
   input  logic [`IFU_WAYS-1:0]                      icv_valid_f,
   input  logic [`IFU_INST_W-1:0]                    fet_data_s1,
   input  logic [`IFU_INST_W-1:0]                    nir_data_s1,
   // error address sources
   input  logic [47:0]                               pc_f,
   input  logic [7:0]                                exu_err_reg_m,
   input  logic [7:0]                                exu_err_synd_m,
   input  logic [`IFU_EADR_HI:`IFU_EADR_LO]          lsu_err_addr,
   input  ifu_err_pkg::eadr_src_e [`IFU_THREADS-1:0] eadr_sel,
   input  logic [47:0]                               asi_wr_data,
   // asi read
   input  ifu_err_pkg::asi_src_e                     asi_src,
   input  ifu_err_pkg::thread_t                      asi_way,
   input  ifu_err_pkg::thread_t                      asi_thr,
   input  logic [`IFU_INST_W-1:0]                    inst_asi_data_s,
   input  logic                                      ld_imask,
   // outputs
   output logic [`IFU_WAYS-1:0]                      tag_pe_s1,
   output logic                                      fet_pe_s1,
   output logic                                      nir_pe_s1,
   output logic [`IFU_LDXA_W-1:0]                    ldxa_data_w2,
   output logic [`IFU_IMASK_W-1:0]                   imask
);

   // flopped tag array and valid bits for the diagnostic read
   logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]                 tags_s1;
   logic [`IFU_WAYS-1:0]                               valid_s1;
   // per-thread error addresses
   logic [`IFU_THREADS-1:0][`IFU_EADR_HI:`IFU_EADR_LO] err_addr;

   ifu_err_parity u_parity (
      .rclk        (rclk),
      .reset       (reset),
      .ict_tags_f  (ict_tags_f),
      .icv_valid_f (icv_valid_f),
      .fet_data_s1 (fet_data_s1),
      .nir_data_s1 (nir_data_s1),
      .tags_s1     (tags_s1),
      .valid_s1    (valid_s1),
      .tag_pe_s1   (tag_pe_s1),
      .fet_pe_s1   (fet_pe_s1),
      .nir_pe_s1   (nir_pe_s1)
   );

   ifu_err_addr_bank u_addr_bank (
      .rclk           (rclk),
      .reset          (reset),
      .pc_f           (pc_f),
      .exu_err_reg_m  (exu_err_reg_m),
      .exu_err_synd_m (exu_err_synd_m),
      .lsu_err_addr   (lsu_err_addr),
      .eadr_sel       (eadr_sel),
      .asi_wr_data    (asi_wr_data),
      .err_addr       (err_addr)
   );

   ifu_err_asi_read u_asi_read (
      .rclk            (rclk),
      .reset           (reset),
      .tags_s1         (tags_s1),
      .valid_s1        (valid_s1),
      .err_addr        (err_addr),
      .asi_src         (asi_src),
      .asi_way         (asi_way),
      .asi_thr         (asi_thr),
      .inst_asi_data_s (inst_asi_data_s),
      .ld_imask        (ld_imask),
      .asi_wr_data     (asi_wr_data),
      .ldxa_data_w2    (ldxa_data_w2),
      .imask           (imask)
   );

endmodule

/* verif/ifu_err_checker.sv */
// checker for the ifu error datapath
// keeps its own copy of every stage and staging flop
// model state moves on the rising edge
// outputs are compared on the falling edge when data and flops have settled
// checks start after the first edge since the flops are undefined before it
`timescale 1ns/100ps
`include "ifu_err_defs.svh"

module ifu_err_checker (
   input  logic                                      rclk,
   input  logic                                      reset,
   input  logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]        ict_tags_f,
   input  logic [`IFU_WAYS-1:0]                      icv_valid_f,
   input  logic [`IFU_INST_W-1:0]                    fet_data_s1,
   input  logic [`IFU_INST_W-1:0]                    nir_data_s1,
   input  logic [47:0]                               pc_f,
   input  logic [7:0]                                exu_err_reg_m,
   input  logic [7:0]                                exu_err_synd_m,
   input  logic [`IFU_EADR_HI:`IFU_EADR_LO]          lsu_err_addr,
   input  ifu_err_pkg::eadr_src_e [`IFU_THREADS-1:0] eadr_sel,
   input  logic [47:0]                               asi_wr_data,
   input  ifu_err_pkg::asi_src_e                     asi_src,
   input  ifu_err_pkg::thread_t                      asi_way,
   input  ifu_err_pkg::thread_t                      asi_thr,
   input  logic [`IFU_INST_W-1:0]                    inst_asi_data_s,
   input  logic                                      ld_imask,
   input  logic [`IFU_WAYS-1:0]                      tag_pe_s1,
   input  logic                                      fet_pe_s1,
   input  logic                                      nir_pe_s1,
   input  logic [`IFU_LDXA_W-1:0]                    ldxa_data_w2,
   input  logic [`IFU_IMASK_W-1:0]                   imask,
   input  int                                        test_id,
   input  logic                                      test_end,
   output int                                        err_total,
   output int                                        check_total
);

   import ifu_err_pkg::*;

   // model state
   logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]                 m_tags;
   logic [`IFU_WAYS-1:0]                               m_valid;
   logic [`IFU_THREADS-1:0][`IFU_EADR_HI:`IFU_EADR_LO] m_eadr;
   logic [`IFU_EADR_HI:`IFU_EADR_LO]                   m_pc_d1;
   logic [`IFU_EADR_HI:`IFU_EADR_LO]                   m_pc_d2;
   logic [`IFU_EADR_HI:`IFU_EADR_LO]                   m_lsu;
   logic [7:0]                                         m_irf_reg;
   logic [7:0]                                         m_irf_synd;
   logic [`IFU_IMASK_W-1:0]                            m_imask;
   logic [`IFU_LDXA_W-1:0]                             m_ldxa;
   logic                                               primed = 1'b0;

   int errs = 0;
   int checks = 0;
   int test_errs = 0;
   int test_checks = 0;

   assign err_total   = errs;
   assign check_total = checks;

   // ------------------------------
   // reference functions
   // ------------------------------
   // 1 when the number of set bits is odd
   function automatic logic odd_parity(input logic [63:0] word);
      int ones;
      ones = 0;
      for (int i = 0; i < 64; i++) begin
         if (word[i]) ones++;
      end
      return (ones % 2) == 1;
   endfunction

   // 24 zeros, syndrome, 4 zeros, register number with bit 4 corrected
   function automatic logic [43:0] irf_ref(input logic [7:0] reg_no, input logic [7:0] synd);
      logic [7:0] fixed;
      fixed    = reg_no;
      fixed[4] = reg_no[4] ^ (reg_no[5] & reg_no[3]);
      return {24'b0, synd, 4'b0, fixed};
   endfunction

   // asi result word in the bit positions the lsu sees
   function automatic logic [63:0] ldxa_ref(
      input asi_src_e    src,
      input logic [28:0] tag_word,
      input logic        valid_bit,
      input logic [43:0] eadr,
      input logic [38:0] mask,
      input logic [33:0] inst
   );
      logic [63:0] word;
      word = '0;
      case (src)
         TAG: begin
            word[34]   = valid_bit;
            word[32]   = tag_word[28];
            word[27:0] = tag_word[27:0];
         end
         EADR:  word[47:4] = eadr;
         IMASK: word[38:0] = mask;
         INST: begin
            word[33]   = inst[0];
            word[32:0] = inst[33:1];
         end
      endcase
      return word;
   endfunction

   function automatic string test_name(input int n);
      case (n)
         1: return "parity flags";
         2: return "irf capture";
         3: return "lsu pc asi capture";
         4: return "asi read sources";
         5: return "imask and reset";
         default: return "unknown";
      endcase
   endfunction

   // ------------------------------
   // model update on the rising edge
   // ------------------------------
   always @(posedge rclk) begin : model_update
      // result word first so it uses the state before this edge
      if (reset) begin
         m_ldxa = '0;
      end else begin
         m_ldxa = ldxa_ref(asi_src, m_tags[asi_way], m_valid[asi_way],
                           m_eadr[asi_thr], m_imask, inst_asi_data_s);
      end
      for (int t = 0; t < `IFU_THREADS; t++) begin
         if (reset) begin
            m_eadr[t] = '0;
         end else begin
            case (eadr_sel[t])
               IRF:     m_eadr[t] = irf_ref(m_irf_reg, m_irf_synd);
               LSU:     m_eadr[t] = m_lsu;
               PC:      m_eadr[t] = m_pc_d2;
               ASI_WR:  m_eadr[t] = asi_wr_data[47:4];
               default: m_eadr[t] = m_eadr[t];
            endcase
         end
      end
      if (reset) begin
         m_imask = '0;
      end else if (ld_imask) begin
         m_imask = asi_wr_data[38:0];
      end
      // pc is staged twice and the rest once
      m_pc_d2    = m_pc_d1;
      m_pc_d1    = pc_f[47:4];
      m_irf_reg  = exu_err_reg_m;
      m_irf_synd = exu_err_synd_m;
      m_lsu      = lsu_err_addr;
      m_tags     = ict_tags_f;
      m_valid    = reset ? '0 : icv_valid_f;
      primed     = 1'b1;
   end

   // ------------------------------
   // comparison on the falling edge
   // ------------------------------
   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      test_checks++;
      if (act !== exp) begin
         errs++;
         test_errs++;
         $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   always @(negedge rclk) begin : compare
      logic [`IFU_WAYS-1:0] exp_pe;
      if (primed) begin
         for (int w = 0; w < `IFU_WAYS; w++) begin
            exp_pe[w] = odd_parity({35'b0, m_tags[w]});
         end
         check_value("tag_pe_s1", {60'b0, exp_pe}, {60'b0, tag_pe_s1});
         check_value("fet_pe_s1", {63'b0, odd_parity({30'b0, fet_data_s1})},
                     {63'b0, fet_pe_s1});
         check_value("nir_pe_s1", {63'b0, odd_parity({30'b0, nir_data_s1})},
                     {63'b0, nir_pe_s1});
         check_value("ldxa_data_w2", m_ldxa, ldxa_data_w2);
         check_value("imask", {25'b0, m_imask}, {25'b0, imask});
      end
      // one line per finished test
      if (test_end) begin
         $display("test %0d %s done: %0d checks, %0d errors",
                  test_id, test_name(test_id), test_checks, test_errs);
         test_checks = 0;
         test_errs   = 0;
      end
   end

endmodule

/* verif/tb_ifu_err_dp.sv */
// testbench top for the ifu error datapath
// inputs change 1 ns after the rising edge, the checker compares on the falling edge
// random data comes from one seed, so every run is the same
// error addresses have no port of their own and are read back through the EADR source
`timescale 1ns/100ps
`include "ifu_err_defs.svh"

module tb_ifu_err_dp;

   import ifu_err_pkg::*;

   // 5 tests of at most 200 cycles plus reset, rounded up
   localparam int TIMEOUT_CYCLES = 1100;

   logic                                      rclk = 1'b0;
   logic                                      reset;
   logic [`IFU_WAYS-1:0][`IFU_TAG_W:0]        ict_tags_f;
   logic [`IFU_WAYS-1:0]                      icv_valid_f;
   logic [`IFU_INST_W-1:0]                    fet_data_s1;
   logic [`IFU_INST_W-1:0]                    nir_data_s1;
   logic [47:0]                               pc_f;
   logic [7:0]                                exu_err_reg_m;
   logic [7:0]                                exu_err_synd_m;
   logic [`IFU_EADR_HI:`IFU_EADR_LO]          lsu_err_addr;
   eadr_src_e [`IFU_THREADS-1:0]              eadr_sel;
   logic [47:0]                               asi_wr_data;
   asi_src_e                                  asi_src;
   thread_t                                   asi_way;
   thread_t                                   asi_thr;
   logic [`IFU_INST_W-1:0]                    inst_asi_data_s;
   logic                                      ld_imask;
   logic [`IFU_WAYS-1:0]                      tag_pe_s1;
   logic                                      fet_pe_s1;
   logic                                      nir_pe_s1;
   logic [`IFU_LDXA_W-1:0]                    ldxa_data_w2;
   logic [`IFU_IMASK_W-1:0]                   imask;

   // test bookkeeping toward the checker
   int     test_id = 1;
   logic   test_end = 1'b0;
   int     err_total;
   int     check_total;
   int     cycle_count = 0;
   integer seed = 77;

   // 10 ns clock
   always #5 rclk = ~rclk;

   ifu_err_dp u_ifu_err_dp (
      .rclk            (rclk),
      .reset           (reset),
      .ict_tags_f      (ict_tags_f),
      .icv_valid_f     (icv_valid_f),
      .fet_data_s1     (fet_data_s1),
      .nir_data_s1     (nir_data_s1),
      .pc_f            (pc_f),
      .exu_err_reg_m   (exu_err_reg_m),
      .exu_err_synd_m  (exu_err_synd_m),
      .lsu_err_addr    (lsu_err_addr),
      .eadr_sel        (eadr_sel),
      .asi_wr_data     (asi_wr_data),
      .asi_src         (asi_src),
      .asi_way         (asi_way),
      .asi_thr         (asi_thr),
      .inst_asi_data_s (inst_asi_data_s),
      .ld_imask        (ld_imask),
      .tag_pe_s1       (tag_pe_s1),
      .fet_pe_s1       (fet_pe_s1),
      .nir_pe_s1       (nir_pe_s1),
      .ldxa_data_w2    (ldxa_data_w2),
      .imask           (imask)
   );

   ifu_err_checker u_checker (
      .rclk            (rclk),
      .reset           (reset),
      .ict_tags_f      (ict_tags_f),
      .icv_valid_f     (icv_valid_f),
      .fet_data_s1     (fet_data_s1),
      .nir_data_s1     (nir_data_s1),
      .pc_f            (pc_f),
      .exu_err_reg_m   (exu_err_reg_m),
      .exu_err_synd_m  (exu_err_synd_m),
      .lsu_err_addr    (lsu_err_addr),
      .eadr_sel        (eadr_sel),
      .asi_wr_data     (asi_wr_data),
      .asi_src         (asi_src),
      .asi_way         (asi_way),
      .asi_thr         (asi_thr),
      .inst_asi_data_s (inst_asi_data_s),
      .ld_imask        (ld_imask),
      .tag_pe_s1       (tag_pe_s1),
      .fet_pe_s1       (fet_pe_s1),
      .nir_pe_s1       (nir_pe_s1),
      .ldxa_data_w2    (ldxa_data_w2),
      .imask           (imask),
      .test_id         (test_id),
      .test_end        (test_end),
      .err_total       (err_total),
      .check_total     (check_total)
   );

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   // 1 ns past the next rising edge
   task automatic next_cycle();
      @(posedge rclk);
      #1;
   endtask

   task automatic rand64(output logic [63:0] v);
      v = {$random(seed), $random(seed)};
   endtask

   // even parity tag word, about half get one bit flipped
   task automatic make_tag(output logic [`IFU_TAG_W:0] tag);
      logic [31:0] r;
      logic [31:0] f;
      int          idx;
      r = $random(seed);
      f = $random(seed);
      tag[`IFU_TAG_W-1:0] = r[`IFU_TAG_W-1:0];
      tag[`IFU_TAG_W]     = ^r[`IFU_TAG_W-1:0];
      if (f[0]) begin
         idx = int'(f[12:8]) % (`IFU_TAG_W + 1);
         tag[idx] = ~tag[idx];
      end
   endtask

   // new tags, valid bits and instruction words
   task automatic randomize_fetch();
      logic [63:0] a;
      logic [63:0] b;
      for (int w = 0; w < `IFU_WAYS; w++) begin
         make_tag(ict_tags_f[w]);
      end
      rand64(a);
      rand64(b);
      icv_valid_f     = a[63:60];
      fet_data_s1     = a[`IFU_INST_W-1:0];
      nir_data_s1     = b[`IFU_INST_W-1:0];
      inst_asi_data_s = {a[59:54], b[61:34]};
   endtask

   // new values on every error address source
   task automatic randomize_sources();
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] c;
      rand64(a);
      rand64(b);
      rand64(c);
      pc_f           = a[47:0];
      lsu_err_addr   = b[`IFU_EADR_HI:`IFU_EADR_LO];
      exu_err_reg_m  = c[7:0];
      exu_err_synd_m = c[15:8];
      asi_wr_data    = {a[63:48], b[63:48], c[63:48]};
   endtask

   task automatic hold_all_threads();
      for (int t = 0; t < `IFU_THREADS; t++) begin
         eadr_sel[t] = HOLD;
      end
   endtask

   // selects one error address, result lands one cycle later
   task automatic read_eadr(input int thr);
      asi_src = EADR;
      asi_thr = thread_t'(thr);
      next_cycle();
   endtask

   // one source for every way or thread index, back to back
   task automatic read_all_indices(input asi_src_e src);
      for (int i = 0; i < `IFU_THREADS; i++) begin
         randomize_fetch();
         asi_src = src;
         asi_way = thread_t'(i);
         asi_thr = thread_t'(i);
         next_cycle();
      end
   endtask

   // strobe seen by the checker on the falling edge
   task automatic finish_test();
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
      test_id  = test_id + 1;
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      reset          = 1'b1;
      ict_tags_f     = '0;
      icv_valid_f    = '0;
      fet_data_s1    = '0;
      nir_data_s1    = '0;
      pc_f           = '0;
      exu_err_reg_m  = '0;
      exu_err_synd_m = '0;
      lsu_err_addr   = '0;
      asi_wr_data    = '0;
      asi_src        = INST;
      asi_way        = '0;
      asi_thr        = '0;
      inst_asi_data_s = '0;
      ld_imask       = 1'b0;
      hold_all_threads();
      repeat (16) next_cycle();
      reset = 1'b0;

      // test 1 parity flags
      repeat (40) begin
         randomize_fetch();
         next_cycle();
      end
      finish_test();

      // test 2 irf captures with bits 5 and 3 set
      for (int t = 0; t < `IFU_THREADS; t++) begin
         repeat (2) begin
            randomize_sources();
            exu_err_reg_m = exu_err_reg_m | 8'h28;
            hold_all_threads();
            next_cycle();
            // staged value from the cycle before is loaded
            randomize_sources();
            eadr_sel[t] = IRF;
            next_cycle();
            hold_all_threads();
            read_eadr(t);
            asi_src = INST;
            next_cycle();
         end
      end
      finish_test();

      // test 3 lsu, pc and asi store captures
      for (int t = 0; t < `IFU_THREADS; t++) begin
         for (int s = 0; s < 3; s++) begin
            randomize_sources();
            eadr_sel[t] = (s == 0) ? LSU : ((s == 1) ? PC : ASI_WR);
            next_cycle();
            hold_all_threads();
            randomize_sources();
            read_eadr(t);
            next_cycle();
         end
      end
      // threads load together while one holds
      randomize_sources();
      eadr_sel[0] = PC;
      eadr_sel[1] = HOLD;
      eadr_sel[2] = LSU;
      eadr_sel[3] = ASI_WR;
      next_cycle();
      randomize_sources();
      eadr_sel[0] = HOLD;
      eadr_sel[1] = IRF;
      eadr_sel[2] = HOLD;
      eadr_sel[3] = PC;
      next_cycle();
      hold_all_threads();
      for (int t = 0; t < `IFU_THREADS; t++) begin
         randomize_sources();
         read_eadr(t);
      end
      finish_test();

      // test 4 every source and index, a new read each cycle
      randomize_sources();
      ld_imask = 1'b1;
      next_cycle();
      ld_imask = 1'b0;
      read_all_indices(TAG);
      read_all_indices(EADR);
      read_all_indices(IMASK);
      read_all_indices(INST);
      next_cycle();
      finish_test();

      // test 5 mask load and hold, then reset in the middle of traffic
      asi_src = IMASK;
      repeat (6) begin
         randomize_sources();
         ld_imask = 1'b1;
         next_cycle();
         ld_imask = 1'b0;
         repeat (3) begin
            randomize_sources();
            next_cycle();
         end
      end
      for (int t = 0; t < `IFU_THREADS; t++) begin
         eadr_sel[t] = ASI_WR;
      end
      ld_imask = 1'b1;
      reset    = 1'b1;
      repeat (2) begin
         randomize_sources();
         next_cycle();
      end
      reset    = 1'b0;
      ld_imask = 1'b0;
      hold_all_threads();
      for (int t = 0; t < `IFU_THREADS; t++) begin
         read_eadr(t);
      end
      asi_src = IMASK;
      next_cycle();
      next_cycle();
      finish_test();

      $display("summary: %0d tests, %0d checks, %0d errors",
               test_id - 1, check_total, err_total);
      if (err_total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // ------------------------------
   // timeout
   // ------------------------------
   always @(posedge rclk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

endmodule

/* sim.f */
+incdir+include
design/ifu_err_pkg.sv
design/ifu_err_parity.sv
design/ifu_err_addr_bank.sv
design/ifu_err_asi_read.sv
design/ifu_err_dp.sv
verif/ifu_err_checker.sv
verif/tb_ifu_err_dp.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -sv -f sim.f --top-module tb_ifu_err_dp \
   -Mdir obj_dir -o tb_ifu_err_dp \
   && ./obj_dir/tb_ifu_err_dp 2>&1 | tee sim.log \
   || { echo "build or simulation error"; exit 1; }

grep -q "Verification failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Verification passed" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
